// File: hw/conv_ctrl_pkg.sv
// ####################
// controller state encoding for the image-filter control unit
// shared by the sequencer, the command decoder and the bound checks
// import with conv_ctrl_pkg::* in the module header
// ####################
package conv_ctrl_pkg;

	localparam int CTRL_STATE_W = 5; // 27 states used

	// every memory read has a one-cycle strobe state and a wait state
	typedef enum logic [CTRL_STATE_W-1:0] {
		S_IDLE,              // waiting for start
		S_FR_RD_SDRAM,       // first row, sdram read strobe
		S_FR_RD_SDRAM_WAIT,  // first row, waiting on sdram data
		S_FR_WR_SRAM,        // first row, copy into row cache
		S_FR_UPD,            // first row, column step
		S_ROW_STEP,          // row counter step, finish check
		S_FC_RD_SRAM,        // first column, row cache read for slot 1
		S_FC_RD_SRAM_WAIT,
		S_FC_WR_WB1,         // slot 1 load
		S_FC_RD_SDRAM,       // first column, sdram read for slot 3
		S_FC_RD_SDRAM_WAIT,
		S_FC_WR_WB3_SRAM,    // slot 3 load plus row cache refresh
		S_FC_UPD,            // first column counter step
		S_AC_RD_SRAM,        // row cache read for slot 2
		S_AC_RD_SRAM_WAIT,
		S_AC_WR_WB2,         // slot 2 load
		S_AC_RD_SDRAM,       // sdram read for slot 4
		S_AC_RD_SDRAM_WAIT,
		S_AC_WR_WB4_SRAM,    // slot 4 load plus row cache refresh
		S_AC_WR_OUT,         // result into output array
		S_AC_SHIFT,          // window shift, address step
		S_AC_UPD,            // column step, rollover check
		S_OC_RD_SRAM,        // output copy, output array read
		S_OC_RD_SRAM_WAIT,
		S_OC_WR_SDRAM,       // output copy, sdram write strobe
		S_OC_UPD,            // write-back column step
		S_FINISH             // one-cycle finish pulse
	} ctrl_state_t;

endpackage

// File: hw/mem_cmd_pkg.sv
// ####################
// mode encodings driven towards the datapath blocks
// window buffer slot select, sram direction and area, sdram address mode
// import with mem_cmd_pkg::* where a mode is driven or checked
// ####################
package mem_cmd_pkg;

	localparam int WB_MODE_W = 3;

	// window buffer layout
	//   | 1 | 2 |
	//   | 3 | 4 |
	typedef enum logic [WB_MODE_W-1:0] {
		WB_NOP   = 3'd0, // hold contents
		WB_S1    = 3'd1, // slot 1 from sram
		WB_S2    = 3'd2, // slot 2 from sram
		WB_SD3   = 3'd3, // slot 3 from sdram
		WB_SD4   = 3'd4, // slot 4 from sdram
		WB_SHIFT = 3'd5  // 2 into 1, 4 into 3
	} wb_mode_t;

	localparam logic SRAM_MODE_READ  = 1'b1;
	localparam logic SRAM_MODE_WRITE = 1'b0;

	localparam logic SRAM_AREA_ROWCACHE = 1'b1; // one picture row
	localparam logic SRAM_AREA_OUTPUT   = 1'b0; // result row

	localparam logic SDRAM_ADDR_READ  = 1'b1; // source picture
	localparam logic SDRAM_ADDR_WRITE = 1'b0; // filtered picture

endpackage

// File: hw/ctrl_sequencer.sv
// ####################
// state register and next-state rules of the filter controller
// advances on start, the sram/sdram data-read levels and the
// column, row and write-back counter rollovers
// ####################
`timescale 1ns/1ps

module ctrl_sequencer import conv_ctrl_pkg::*;
(
	input  logic        clk,
	input  logic        n_rst,
	input  logic        start_i,
	input  logic        sram_data_read_i,
	input  logic        sdram_data_read_i,
	input  logic        col_rollover_i,
	input  logic        row_rollover_i,
	input  logic        wr_rollover_i,
	output ctrl_state_t state_o
);

	ctrl_state_t next_state;

	always_comb
	begin : next_state_logic
		next_state = state_o; // hold by default
		case (state_o)
			S_IDLE:
			begin
				if (start_i)
					next_state = S_FR_RD_SDRAM;
			end

			// first row fill of the row cache
			S_FR_RD_SDRAM, S_FR_RD_SDRAM_WAIT:
			begin
				if (sdram_data_read_i)
					next_state = S_FR_WR_SRAM;
				else
					next_state = S_FR_RD_SDRAM_WAIT; // strobe drops while waiting
			end
			S_FR_WR_SRAM:  next_state = S_FR_UPD;
			S_FR_UPD:
			begin
				if (col_rollover_i)
					next_state = S_ROW_STEP;
				else
					next_state = S_FR_RD_SDRAM;
			end

			S_ROW_STEP:
			begin
				if (row_rollover_i)
					next_state = S_FINISH;
				else
					next_state = S_FC_RD_SRAM;
			end

			// first column, slots 1 and 3
			S_FC_RD_SRAM, S_FC_RD_SRAM_WAIT:
			begin
				if (sram_data_read_i)
					next_state = S_FC_WR_WB1;
				else
					next_state = S_FC_RD_SRAM_WAIT;
			end
			S_FC_WR_WB1:   next_state = S_FC_RD_SDRAM;
			S_FC_RD_SDRAM, S_FC_RD_SDRAM_WAIT:
			begin
				if (sdram_data_read_i)
					next_state = S_FC_WR_WB3_SRAM;
				else
					next_state = S_FC_RD_SDRAM_WAIT;
			end
			S_FC_WR_WB3_SRAM: next_state = S_FC_UPD;
			S_FC_UPD:      next_state = S_AC_RD_SRAM;

			// remaining columns, slots 2 and 4 then result and shift
			S_AC_RD_SRAM, S_AC_RD_SRAM_WAIT:
			begin
				if (sram_data_read_i)
					next_state = S_AC_WR_WB2;
				else
					next_state = S_AC_RD_SRAM_WAIT;
			end
			S_AC_WR_WB2:   next_state = S_AC_RD_SDRAM;
			S_AC_RD_SDRAM, S_AC_RD_SDRAM_WAIT:
			begin
				if (sdram_data_read_i)
					next_state = S_AC_WR_WB4_SRAM;
				else
					next_state = S_AC_RD_SDRAM_WAIT;
			end
			S_AC_WR_WB4_SRAM: next_state = S_AC_WR_OUT;
			S_AC_WR_OUT:   next_state = S_AC_SHIFT;
			S_AC_SHIFT:    next_state = S_AC_UPD;
			S_AC_UPD:
			begin
				if (col_rollover_i)
					next_state = S_OC_RD_SRAM; // row done, copy results out
				else
					next_state = S_AC_RD_SDRAM;
			end

			// output row copy to sdram
			S_OC_RD_SRAM, S_OC_RD_SRAM_WAIT:
			begin
				if (sram_data_read_i)
					next_state = S_OC_WR_SDRAM;
				else
					next_state = S_OC_RD_SRAM_WAIT;
			end
			S_OC_WR_SDRAM: next_state = S_OC_UPD;
			S_OC_UPD:
			begin
				if (wr_rollover_i)
					next_state = S_ROW_STEP;
				else
					next_state = S_OC_RD_SRAM;
			end

			S_FINISH:      next_state = S_IDLE;
			default:       next_state = S_IDLE; // unused codes recover
		endcase
	end

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (!n_rst)
			state_o <= S_IDLE;
		else
			state_o <= next_state;
	end

endmodule

// File: hw/ctrl_cmd_decoder.sv
// ####################
// per-state decode of the controller strobes and mode levels
// purely combinational, outputs follow the state in the same cycle
// strobes default low, modes default to the idle presets
// ####################
`timescale 1ns/1ps

module ctrl_cmd_decoder import conv_ctrl_pkg::*, mem_cmd_pkg::*;
(
	input  ctrl_state_t state_i,
	output logic        col_en_o,
	output logic        row_en_o,
	output logic        wr_col_en_o,
	output logic        sram_addr_en_o,
	output logic        sdram_addr_en_o,
	output logic        wb_en_o,
	output logic        sram_en_o,
	output logic        sdram_read_en_o,
	output logic        sdram_write_en_o,
	output logic        finish_o,
	output wb_mode_t    wb_mode_o,
	output logic        sram_mode_o,
	output logic        sram_area_o,
	output logic        sdram_addr_mode_o
);

	always_comb
	begin : cmd_decode
		col_en_o          = 1'b0;
		row_en_o          = 1'b0;
		wr_col_en_o       = 1'b0;
		sram_addr_en_o    = 1'b0;
		sdram_addr_en_o   = 1'b0;
		wb_en_o           = 1'b0;
		sram_en_o         = 1'b0;
		sdram_read_en_o   = 1'b0;
		sdram_write_en_o  = 1'b0;
		finish_o          = 1'b0;
		wb_mode_o         = WB_NOP;
		sram_mode_o       = SRAM_MODE_WRITE;
		sram_area_o       = SRAM_AREA_ROWCACHE;
		sdram_addr_mode_o = SDRAM_ADDR_READ;

		case (state_i)
			S_FR_RD_SDRAM: sdram_read_en_o = 1'b1;
			S_FR_WR_SRAM:  sram_en_o = 1'b1; // row cache write
			S_FR_UPD:
			begin
				col_en_o        = 1'b1;
				sram_addr_en_o  = 1'b1;
				sdram_addr_en_o = 1'b1;
			end
			S_ROW_STEP:
			begin
				row_en_o    = 1'b1;
				sram_mode_o = SRAM_MODE_READ; // set up the column reads
			end

			S_FC_RD_SRAM, S_FC_RD_SRAM_WAIT, S_FC_WR_WB1:
			begin
				sram_en_o   = (state_i == S_FC_RD_SRAM); // strobe only on first cycle
				wb_en_o     = (state_i == S_FC_WR_WB1);
				wb_mode_o   = WB_S1;
				sram_mode_o = SRAM_MODE_READ;
			end
			S_FC_RD_SDRAM, S_FC_RD_SDRAM_WAIT:
			begin
				sdram_read_en_o = (state_i == S_FC_RD_SDRAM);
				wb_mode_o       = WB_SD3; // sram stays in write for the refresh
			end
			S_FC_WR_WB3_SRAM:
			begin
				wb_en_o   = 1'b1;
				sram_en_o = 1'b1; // same pixel goes to the row cache
				wb_mode_o = WB_SD3;
			end
			S_FC_UPD:
			begin
				col_en_o        = 1'b1;
				sram_addr_en_o  = 1'b1;
				sdram_addr_en_o = 1'b1;
				wb_mode_o       = WB_S2;
				sram_mode_o     = SRAM_MODE_READ;
			end

			S_AC_RD_SRAM, S_AC_RD_SRAM_WAIT:
			begin
				sram_en_o   = (state_i == S_AC_RD_SRAM);
				wb_mode_o   = WB_S2;
				sram_mode_o = SRAM_MODE_READ;
			end
			S_AC_WR_WB2:
			begin
				wb_en_o   = 1'b1;
				wb_mode_o = WB_S2;
			end
			S_AC_RD_SDRAM:
			begin
				sdram_read_en_o = 1'b1;
				wb_mode_o       = WB_SD4;
				sram_mode_o     = SRAM_MODE_READ;
			end
			S_AC_RD_SDRAM_WAIT: wb_mode_o = WB_SD4; // sram already set to write
			S_AC_WR_WB4_SRAM:
			begin
				wb_en_o   = 1'b1;
				sram_en_o = 1'b1; // row cache refresh
				wb_mode_o = WB_SD4;
			end
			S_AC_WR_OUT:
			begin
				sram_en_o   = 1'b1;
				wb_mode_o   = WB_SHIFT; // ready for next cycle shift
				sram_area_o = SRAM_AREA_OUTPUT;
			end
			S_AC_SHIFT:
			begin
				wb_en_o         = 1'b1;
				sram_addr_en_o  = 1'b1;
				sdram_addr_en_o = 1'b1;
				wb_mode_o       = WB_SHIFT;
				sram_mode_o     = SRAM_MODE_READ;
				sram_area_o     = SRAM_AREA_OUTPUT;
			end
			S_AC_UPD:
			begin
				col_en_o       = 1'b1;
				sram_addr_en_o = 1'b1; // sdram address already stepped
				wb_mode_o      = WB_SHIFT;
				sram_mode_o    = SRAM_MODE_READ;
			end

			S_OC_RD_SRAM, S_OC_RD_SRAM_WAIT, S_OC_WR_SDRAM, S_OC_UPD:
			begin
				sram_en_o        = (state_i == S_OC_RD_SRAM);
				sdram_write_en_o = (state_i == S_OC_WR_SDRAM);
				wr_col_en_o      = (state_i == S_OC_UPD);
				sram_addr_en_o   = (state_i == S_OC_UPD);
				sdram_addr_en_o  = (state_i == S_OC_UPD);
				sram_mode_o      = SRAM_MODE_READ;
				sram_area_o      = SRAM_AREA_OUTPUT;
				if (state_i != S_OC_RD_SRAM)
					sdram_addr_mode_o = SDRAM_ADDR_WRITE; // switch after the read strobe
			end

			S_FINISH:
			begin
				finish_o    = 1'b1;
				sram_mode_o = SRAM_MODE_READ;
			end
			default: ; // idle and first-row wait keep the presets
		endcase
	end

endmodule

// File: hw/conv_ctrl_top.sv
// ####################
// control unit of the 2x2 window image filter
// sequencer feeds its state to the command decoder
// counters, address calculators, buffers and memories sit outside
// ####################
`timescale 1ns/1ps

module conv_ctrl_top import conv_ctrl_pkg::*, mem_cmd_pkg::*;
(
	input  logic     clk,
	input  logic     n_rst,
	input  logic     start_i,           // start strobe
	input  logic     sram_data_read_i,  // sram data valid level
	input  logic     sdram_data_read_i, // sdram data valid level
	input  logic     col_rollover_i,
	input  logic     row_rollover_i,
	input  logic     wr_rollover_i,
	output logic     col_en_o,
	output logic     row_en_o,
	output logic     wr_col_en_o,
	output logic     sram_addr_en_o,
	output logic     sdram_addr_en_o,
	output logic     wb_en_o,
	output logic     sram_en_o,
	output logic     sdram_read_en_o,
	output logic     sdram_write_en_o,
	output logic     finish_o,
	output wb_mode_t wb_mode_o,
	output logic     sram_mode_o,
	output logic     sram_area_o,
	output logic     sdram_addr_mode_o
);

	ctrl_state_t state;

	ctrl_sequencer u_seq (
		.clk               (clk),
		.n_rst             (n_rst),
		.start_i           (start_i),
		.sram_data_read_i  (sram_data_read_i),
		.sdram_data_read_i (sdram_data_read_i),
		.col_rollover_i    (col_rollover_i),
		.row_rollover_i    (row_rollover_i),
		.wr_rollover_i     (wr_rollover_i),
		.state_o           (state)
	);

	ctrl_cmd_decoder u_dec (
		.state_i           (state),
		.col_en_o          (col_en_o),
		.row_en_o          (row_en_o),
		.wr_col_en_o       (wr_col_en_o),
		.sram_addr_en_o    (sram_addr_en_o),
		.sdram_addr_en_o   (sdram_addr_en_o),
		.wb_en_o           (wb_en_o),
		.sram_en_o         (sram_en_o),
		.sdram_read_en_o   (sdram_read_en_o),
		.sdram_write_en_o  (sdram_write_en_o),
		.finish_o          (finish_o),
		.wb_mode_o         (wb_mode_o),
		.sram_mode_o       (sram_mode_o),
		.sram_area_o       (sram_area_o),
		.sdram_addr_mode_o (sdram_addr_mode_o)
	);

endmodule

// File: verification/conv_ctrl_asserts.sv
// ####################
// concurrent checks on the decoder command outputs
// bound into ctrl_cmd_decoder by the testbench
// clock and reset come in from the testbench top
// ####################
`timescale 1ns/1ps

module conv_ctrl_asserts import mem_cmd_pkg::*;
(
	input logic     clk,
	input logic     n_rst,
	input logic     sdram_read_en_i,
	input logic     sdram_write_en_i,
	input logic     finish_i,
	input logic     wb_en_i,
	input wb_mode_t wb_mode_i
);

	sdram_cmd_excl: assert property (@(posedge clk) disable iff (!n_rst)
		!(sdram_read_en_i && sdram_write_en_i)) // one sdram command per cycle
		else $error("sdram read and write strobes high in the same cycle");

	sdram_read_pulse: assert property (@(posedge clk) disable iff (!n_rst)
		sdram_read_en_i |=> !sdram_read_en_i) // read state never repeats
		else $error("sdram read strobe longer than one cycle");

	finish_pulse_len: assert property (@(posedge clk) disable iff (!n_rst)
		finish_i |=> !finish_i)
		else $error("finish strobe longer than one cycle");

	// a buffer write must name a slot or the shift
	wb_mode_valid: assert property (@(posedge clk) disable iff (!n_rst)
		wb_en_i |-> (wb_mode_i != WB_NOP))
		else $error("window buffer enabled with no mode selected");

endmodule

// File: verification/conv_ctrl_tb.sv
// ####################
// directed testbench for the filter control unit
// models the column, row and write-back counters and both memories
// memory waits of 0 to 3 cycles come from an lcg
// build and run with run.sh, sources lie in sources.f
// ####################
`timescale 1ns/1ps

module conv_ctrl_tb import mem_cmd_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int COLS       = 4;    // picture width
	localparam int ROWS       = 3;    // picture height
	localparam int MAX_CYCLES = 4000; // two pictures take under 600 at the longest waits
	localparam logic [9:0] FINISH_ONLY = 10'd1; // finish is the last strobe bit
	localparam logic [5:0] IDLE_MODES  =
		{WB_NOP, SRAM_MODE_WRITE, SRAM_AREA_ROWCACHE, SDRAM_ADDR_READ};

	logic     clk;
	logic     n_rst             = 1'b0;
	logic     start_i           = 1'b0;
	logic     sram_data_read_i  = 1'b0;
	logic     sdram_data_read_i = 1'b0;
	logic     col_rollover_i    = 1'b0;
	logic     row_rollover_i    = 1'b0;
	logic     wr_rollover_i     = 1'b0;
	logic     col_en_o;
	logic     row_en_o;
	logic     wr_col_en_o;
	logic     sram_addr_en_o;
	logic     sdram_addr_en_o;
	logic     wb_en_o;
	logic     sram_en_o;
	logic     sdram_read_en_o;
	logic     sdram_write_en_o;
	logic     finish_o;
	wb_mode_t wb_mode_o;
	logic     sram_mode_o;
	logic     sram_area_o;
	logic     sdram_addr_mode_o;

	logic [31:0] lcg_state = 32'd19273;
	int          cycles    = 0;
	int          col_cnt   = 0; // counter stand-ins
	int          row_cnt   = 0;
	int          wr_cnt    = 0;
	logic        sram_pend  = 1'b0; // read issued, level not yet raised
	logic        sdram_pend = 1'b0;
	int          sram_left  = 0;
	int          sdram_left = 0;

	conv_ctrl_top dut_i (.*);

	bind ctrl_cmd_decoder conv_ctrl_asserts cmd_checks (
		.clk              (conv_ctrl_tb.clk),
		.n_rst            (conv_ctrl_tb.n_rst),
		.sdram_read_en_i  (sdram_read_en_o),
		.sdram_write_en_i (sdram_write_en_o),
		.finish_i         (finish_o),
		.wb_en_i          (wb_en_o),
		.wb_mode_i        (wb_mode_o)
	);

	initial
	begin : clock_gen
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic logic [9:0] strobe_bits();
		return {col_en_o, row_en_o, wr_col_en_o, sram_addr_en_o, sdram_addr_en_o,
			wb_en_o, sram_en_o, sdram_read_en_o, sdram_write_en_o, finish_o};
	endfunction

	function automatic logic [5:0] mode_bits();
		return {wb_mode_o, sram_mode_o, sram_area_o, sdram_addr_mode_o};
	endfunction

	// counters roll over on their last count, memories answer after a random wait
	always @(posedge clk)
	begin : datapath_model
		logic [31:0] rnd;
		logic        sram_ready;
		logic        sdram_ready;
		if (!n_rst)
		begin
			col_cnt = 0;
			row_cnt = 0;
			wr_cnt = 0;
			sram_pend = 1'b0;
			sdram_pend = 1'b0;
			col_rollover_i <= 1'b0;
			row_rollover_i <= 1'b0;
			wr_rollover_i <= 1'b0;
			sram_data_read_i <= 1'b0;
			sdram_data_read_i <= 1'b0;
		end
		else
		begin
			if (col_en_o)
				col_cnt = (col_cnt == COLS - 1) ? 0 : col_cnt + 1;
			if (row_en_o)
				row_cnt = (row_cnt == ROWS) ? 0 : row_cnt + 1; // extra step flags the end
			if (wr_col_en_o)
				wr_cnt = (wr_cnt == COLS - 1) ? 0 : wr_cnt + 1;
			col_rollover_i <= (col_cnt == COLS - 1);
			row_rollover_i <= (row_cnt == ROWS);
			wr_rollover_i <= (wr_cnt == COLS - 1);

			if (sram_en_o && sram_mode_o == SRAM_MODE_READ)
			begin
				rnd = lcg_next();
				sram_left = int'(rnd[17:16]); // 0 to 3 cycles
				sram_pend = 1'b1;
			end
			else if (sram_pend && sram_left > 0)
				sram_left = sram_left - 1;
			sram_ready = sram_pend && (sram_left == 0);
			if (sram_ready)
				sram_pend = 1'b0;
			sram_data_read_i <= sram_ready; // high for one cycle

			if (sdram_read_en_o)
			begin
				rnd = lcg_next();
				sdram_left = int'(rnd[17:16]);
				sdram_pend = 1'b1;
			end
			else if (sdram_pend && sdram_left > 0)
				sdram_left = sdram_left - 1;
			sdram_ready = sdram_pend && (sdram_left == 0);
			if (sdram_ready)
				sdram_pend = 1'b0;
			sdram_data_read_i <= sdram_ready;
		end
	end

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("tests failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic value_error(input string test, input int expected, input int actual);
		stop_run($sformatf("[ERROR] %s expected 0x%0h actual 0x%0h", test, expected, actual));
	endtask

	// outputs read here still belong to the cycle that just ended
	task automatic step_clock();
		@(posedge clk);
		cycles++;
		if (cycles > MAX_CYCLES)
			stop_run($sformatf("timeout, controller stuck after %0d cycles", MAX_CYCLES));
	endtask

	task automatic idle_after_reset();
		repeat (10)
		begin
			step_clock();
			assert (strobe_bits() == '0)
				else value_error("idle_after_reset", 0, int'(strobe_bits()));
			assert (mode_bits() == IDLE_MODES)
				else value_error("idle_after_reset", int'(IDLE_MODES), int'(mode_bits()));
		end
	endtask

	task automatic first_row_fill();
		int   reads = 0;
		int   writes = 0;
		logic data_seen = 1'b0;
		start_i <= 1'b1;
		step_clock();
		start_i <= 1'b0; // one-cycle start strobe
		do
		begin
			step_clock();
			assert ({sram_addr_en_o, sdram_addr_en_o} == {2{col_en_o}}) // addresses follow the column
				else value_error("first_row_fill", int'({2{col_en_o}}),
					int'({sram_addr_en_o, sdram_addr_en_o}));
			if (sdram_read_en_o)
			begin
				assert (reads == writes)
					else stop_run("sdram read issued before the previous row cache write");
				reads++;
			end
			if (sdram_data_read_i)
				data_seen = 1'b1;
			if (sram_en_o)
			begin
				assert (data_seen && reads == writes + 1)
					else stop_run("row cache write without a completed sdram read");
				assert ({sram_mode_o, sram_area_o} == {SRAM_MODE_WRITE, SRAM_AREA_ROWCACHE})
					else value_error("first_row_fill", int'({SRAM_MODE_WRITE, SRAM_AREA_ROWCACHE}),
						int'({sram_mode_o, sram_area_o}));
				data_seen = 1'b0;
				writes++;
			end
		end
		while (!row_en_o); // row step only after the whole row
		assert (reads == COLS) else value_error("first_row_fill", COLS, reads);
		assert (writes == COLS) else value_error("first_row_fill", COLS, writes);
	endtask

	task automatic window_loading(input int row);
		wb_mode_t expected[$];
		int       loads = 0;
		string    test;
		test = $sformatf("window_loading row %0d", row);
		expected.push_back(WB_S1); // first column, top then bottom
		expected.push_back(WB_SD3);
		expected.push_back(WB_S2); // slot 2 read once, the loop re-enters at the sdram read
		for (int col = 1; col < COLS; col++)
		begin
			expected.push_back(WB_SD4);
			expected.push_back(WB_SHIFT);
		end
		while (loads < expected.size())
		begin
			step_clock();
			assert (!sdram_write_en_o) else stop_run("sdram write during window loading");
			if (wb_en_o)
			begin
				assert (wb_mode_o == expected[loads])
					else value_error(test, int'(expected[loads]), int'(wb_mode_o));
				loads++;
			end
		end
	endtask

	task automatic output_copy(input int row);
		int    writes = 0;
		logic  read_done = 1'b0;
		logic  step_due = 1'b0;
		string test;
		test = $sformatf("output_copy row %0d", row);
		do
		begin
			step_clock();
			assert (!wb_en_o) else stop_run("window buffer written during output copy");
			if (step_due)
			begin
				assert (wr_col_en_o) else stop_run("write-back counter not stepped after sdram write");
				assert ({sram_addr_en_o, sdram_addr_en_o} == 2'b11) // both addresses step too
					else value_error(test, 3, int'({sram_addr_en_o, sdram_addr_en_o}));
				step_due = 1'b0;
			end
			if (sram_en_o && sram_mode_o == SRAM_MODE_READ)
			begin
				assert (sram_area_o == SRAM_AREA_OUTPUT)
					else value_error(test, int'(SRAM_AREA_OUTPUT), int'(sram_area_o));
				read_done = 1'b1;
			end
			if (sdram_write_en_o)
			begin
				assert (read_done) else stop_run("sdram write without an output array read");
				assert ({sdram_addr_mode_o, sram_area_o} == {SDRAM_ADDR_WRITE, SRAM_AREA_OUTPUT})
					else value_error(test, int'({SDRAM_ADDR_WRITE, SRAM_AREA_OUTPUT}),
						int'({sdram_addr_mode_o, sram_area_o}));
				read_done = 1'b0;
				step_due = 1'b1;
				writes++;
			end
		end
		while (!row_en_o); // back at the row step
		assert (writes == COLS) else value_error(test, COLS, writes);
	endtask

	task automatic finish_pulse();
		step_clock();
		assert (strobe_bits() == FINISH_ONLY)
			else value_error("finish_pulse", int'(FINISH_ONLY), int'(strobe_bits()));
		repeat (4)
		begin
			step_clock(); // idle again, no second pulse
			assert (strobe_bits() == '0)
				else value_error("finish_pulse", 0, int'(strobe_bits()));
			assert (mode_bits() == IDLE_MODES)
				else value_error("finish_pulse", int'(IDLE_MODES), int'(mode_bits()));
		end
	endtask

	initial
	begin : main_sequence
		repeat (2)
			step_clock();
		n_rst <= 1'b1;
		idle_after_reset();
		for (int picture = 0; picture < 2; picture++)
		begin
			first_row_fill(); // second pass restarts from idle
			for (int row = 0; row < ROWS; row++)
			begin
				window_loading(row);
				output_copy(row);
			end
			finish_pulse();
		end
		$display("all tests passed");
		$finish;
	end

endmodule

// File: sources.f
hw/conv_ctrl_pkg.sv
hw/mem_cmd_pkg.sv
hw/ctrl_sequencer.sv
hw/ctrl_cmd_decoder.sv
hw/conv_ctrl_top.sv
verification/conv_ctrl_asserts.sv
verification/conv_ctrl_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the controller testbench with verilator and run it
# exit status is nonzero when the simulation fails
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
	--top-module conv_ctrl_tb \
	-f sources.f \
	-o conv_ctrl_sim
./obj_dir/conv_ctrl_sim
